// File: hw/mem_exerciser_defs.svh
`ifndef MEM_EXERCISER_DEFS_SVH
`define MEM_EXERCISER_DEFS_SVH

// Walk address and pattern ROM address width
`define EX_ADDR_W 16

// Address width of the memory port
`define EX_MEM_ADDR_W 28

// Data width of ROM words and memory data
`define EX_DATA_W 32

// Last walk address of one pass, wraps to 0 after its read
`define EX_LAST_ADDR 15

// Idle cycles between two commands, at least 1
`define EX_CYCLE_DELAY 2

// Width of each status counter
`define EX_CNT_W 16

`endif

// File: hw/mem_cmd_pkg.sv
`default_nettype none

`include "mem_exerciser_defs.svh"

package mem_cmd_pkg;

	// One command on the memory port
	typedef struct packed {
		// Set for a write, clear for a read
		logic rw;
		logic [`EX_MEM_ADDR_W-1:0] addr;
		logic [`EX_DATA_W-1:0] wdata;
	} mem_cmd_t;

	// Expected read result, handed to the checker on read acceptance
	typedef struct packed {
		// Walk address of the read
		logic [`EX_ADDR_W-1:0] addr;
		logic [`EX_DATA_W-1:0] data;
	} exp_t;

endpackage

`default_nettype wire

// File: hw/exerciser_pkg.sv
`default_nettype none

`include "mem_exerciser_defs.svh"

package exerciser_pkg;

	// Status report of the exerciser
	typedef struct packed {
		// Completed walks over the whole address range
		logic [`EX_CNT_W-1:0] pass_count;
		// Failed reads, sticks at all ones
		logic [`EX_CNT_W-1:0] error_count;
		// Walk address of the latest failed read
		logic [`EX_CNT_W-1:0] fail_addr;
	} ex_status_t;

endpackage

`default_nettype wire

// File: hw/pattern_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_exerciser_defs.svh"

module pattern_rom (
	input wire clk,
	input wire [`EX_ADDR_W-1:0] rom_addr,
	output logic [`EX_DATA_W-1:0] rom_data
);

	// Each half of the data word
	localparam int HALF_W = `EX_DATA_W / 2;

	logic [HALF_W-1:0] addr_half;

	// Address sized to one half word
	assign addr_half = HALF_W'(rom_addr);

	// Address on top, its inverse below
	// Registered like a block ROM, one cycle of read latency
	always_ff @(posedge clk)
	begin
		rom_data <= {addr_half, ~addr_half};
	end

	// Walk must stay inside one pass
	addr_in_range: assert property (
		@(posedge clk) !$isunknown(rom_addr) |-> rom_addr <= `EX_ADDR_W'(`EX_LAST_ADDR)
	) else $error("pattern_rom address %0d beyond last address", rom_addr);

endmodule

`default_nettype wire

// File: hw/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_exerciser_defs.svh"

module cmd_sequencer (
	input wire clk,
	input wire rst,
	input wire enable,
	output logic [`EX_ADDR_W-1:0] rom_addr,
	input wire [`EX_DATA_W-1:0] rom_data,
	output mem_cmd_pkg::mem_cmd_t mem_cmd,
	output logic mem_valid,
	input wire mem_ready,
	output logic rd_done,
	output mem_cmd_pkg::exp_t rd_exp,
	output logic pass_done
);

	localparam int GAP_W = $clog2(`EX_CYCLE_DELAY + 1);
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`EX_CYCLE_DELAY);
	localparam logic [`EX_ADDR_W-1:0] LAST_ADDR = `EX_ADDR_W'(`EX_LAST_ADDR);

	// Idle, ROM read, command on the port, idle gap
	typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_ISSUE, ST_GAP} state_t;

	state_t state;
	// Set while the current or next command is a read
	logic phase_rd;
	logic [`EX_ADDR_W-1:0] addr_q;
	logic [`EX_ADDR_W-1:0] addr_nxt;
	logic [GAP_W-1:0] gap_cnt;
	logic accept;
	logic gap_end;
	logic issue;
	mem_cmd_pkg::mem_cmd_t next_cmd;

	////////////////////////////////////////
	// Handshake and next address
	////////////////////////////////////////

	assign accept = mem_valid & mem_ready;
	assign gap_end = (state == ST_GAP) && (gap_cnt == GAP_LAST);
	// Present a command after the ROM read or at the end of a gap
	assign issue = (state == ST_FETCH) || (gap_end && enable);

	// Step after an accepted read, wrap after the last address
	always_comb
	begin
		addr_nxt = addr_q;
		if (accept && phase_rd)
			addr_nxt = (addr_q == LAST_ADDR) ? '0 : addr_q + 1'b1;
	end

	// ROM looks ahead so the next word is ready after a 1-cycle gap
	assign rom_addr = addr_nxt;

	// Write data and expected data both from the current ROM word
	always_comb
	begin
		next_cmd.rw = ~phase_rd;
		next_cmd.addr = `EX_MEM_ADDR_W'(addr_q);
		next_cmd.wdata = rom_data;
	end

	////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			phase_rd <= 1'b0;
			addr_q <= '0;
			gap_cnt <= '0;
			mem_valid <= 1'b0;
		end
		else
		begin
			addr_q <= addr_nxt;
			case (state)
				ST_IDLE:
				begin
					// Walk resumes here after a stop
					if (enable)
						state <= ST_FETCH;
				end
				ST_FETCH:
				begin
					mem_valid <= 1'b1;
					state <= ST_ISSUE;
				end
				ST_ISSUE:
				begin
					// Hold the command until the memory takes it
					if (accept)
					begin
						mem_valid <= 1'b0;
						phase_rd <= ~phase_rd;
						gap_cnt <= GAP_W'(1);
						state <= ST_GAP;
					end
				end
				ST_GAP:
				begin
					if (gap_end)
					begin
						if (enable)
						begin
							mem_valid <= 1'b1;
							state <= ST_ISSUE;
						end
						else
							state <= ST_IDLE;
					end
					else
						gap_cnt <= gap_cnt + 1'b1;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Command payload
	always_ff @(posedge clk)
	begin
		if (issue)
			mem_cmd <= next_cmd;
	end

	////////////////////////////////////////
	// Read results to the checker
	////////////////////////////////////////

	assign rd_done = accept & phase_rd;
	assign pass_done = rd_done && (addr_q == LAST_ADDR);

	always_comb
	begin
		rd_exp.addr = addr_q;
		rd_exp.data = mem_cmd.wdata;
	end

	// Waiting command stays on the port unchanged
	cmd_held: assert property (
		@(posedge clk) disable iff (rst)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_cmd)
	) else $error("mem_cmd changed while waiting for mem_ready");

	// Port idle for the whole gap after each accepted command
	gap_idle: assert property (
		@(posedge clk) disable iff (rst)
		accept |=> !mem_valid [*`EX_CYCLE_DELAY]
	) else $error("mem_valid high inside the idle gap");

endmodule

`default_nettype wire

// File: hw/readback_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_exerciser_defs.svh"

module readback_checker (
	input wire clk,
	input wire rst,
	input wire rd_done,
	input wire mem_cmd_pkg::exp_t rd_exp,
	input wire [`EX_DATA_W-1:0] mem_rdata,
	input wire pass_done,
	output logic error,
	output exerciser_pkg::ex_status_t status
);

	logic mismatch;

	// Read data is valid in the ready cycle of the read
	assign mismatch = (mem_rdata != rd_exp.data);

	////////////////////////////////////////
	// Error level and counters
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			error <= 1'b0;
			status <= '0;
		end
		else
		begin
			if (rd_done)
			begin
				if (mismatch)
				begin
					error <= 1'b1;
					// Saturates instead of wrapping
					if (status.error_count != '1)
						status.error_count <= status.error_count + 1'b1;
					status.fail_addr <= `EX_CNT_W'(rd_exp.addr);
				end
				else
					error <= 1'b0;
			end
			// One full walk finished
			if (pass_done)
				status.pass_count <= status.pass_count + 1'b1;
		end
	end

	// Pass end only on the read of the last address
	pass_on_read: assert property (
		@(posedge clk) disable iff (rst) pass_done |-> rd_done
	) else $error("pass_done without a completed read");

endmodule

`default_nettype wire

// File: hw/mem_exerciser.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_exerciser_defs.svh"

module mem_exerciser (
	input wire clk,
	input wire rst,
	input wire enable,
	output mem_cmd_pkg::mem_cmd_t mem_cmd,
	output logic mem_valid,
	input wire mem_ready,
	input wire [`EX_DATA_W-1:0] mem_rdata,
	output logic error,
	output exerciser_pkg::ex_status_t status
);

	// Sequencer and ROM
	logic [`EX_ADDR_W-1:0] rom_addr;
	logic [`EX_DATA_W-1:0] rom_data;

	// Sequencer to checker
	logic rd_done;
	logic pass_done;
	mem_cmd_pkg::exp_t rd_exp;

	pattern_rom rom_i (
		.clk(clk),
		.rom_addr(rom_addr),
		.rom_data(rom_data)
	);

	cmd_sequencer seq_i (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.mem_cmd(mem_cmd),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.rd_done(rd_done),
		.rd_exp(rd_exp),
		.pass_done(pass_done)
	);

	readback_checker chk_i (
		.clk(clk),
		.rst(rst),
		.rd_done(rd_done),
		.rd_exp(rd_exp),
		.mem_rdata(mem_rdata),
		.pass_done(pass_done),
		.error(error),
		.status(status)
	);

endmodule

`default_nettype wire

// File: test/tb_mem_exerciser.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_exerciser_defs.svh"

module tb_mem_exerciser;

	localparam int LAST = `EX_LAST_ADDR;
	localparam int GAP = `EX_CYCLE_DELAY;
	localparam int HALF_W = `EX_DATA_W / 2;
	localparam int CMDS_PER_PASS = 2 * (LAST + 1);
	localparam int TIMEOUT_CYCLES = (LAST + 1) * 2 * (GAP + 6) * 4;
	localparam int STALL_CYCLES = 10;
	localparam int CORRUPT_ADDR = 5;

	logic clk = 1'b0;
	logic rst;
	logic enable;
	mem_cmd_pkg::mem_cmd_t mem_cmd;
	logic mem_valid;
	logic mem_ready = 1'b0;
	logic [`EX_DATA_W-1:0] mem_rdata = '0;
	logic error;
	exerciser_pkg::ex_status_t status;

	// Memory model state
	logic [`EX_DATA_W-1:0] mem_array [0:(1 << `EX_ADDR_W) - 1];
	mem_cmd_pkg::mem_cmd_t cmd_log [$];
	integer seed = 32'hf2c7;
	logic busy = 1'b0;
	int wait_cnt = 0;
	// Forced stall requested by count and acknowledged by the model
	int stall_req;
	int stall_ack = 0;
	logic corrupt_en;
	logic [`EX_MEM_ADDR_W-1:0] corrupt_addr;

	// Hold monitor
	logic prev_valid = 1'b0;
	mem_cmd_pkg::mem_cmd_t prev_cmd;
	int held_cycles = 0;

	int cycles = 0;
	int test_errors = 0;
	int order_errors = 0;
	int hold_errors = 0;

	mem_exerciser dut_i (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.mem_cmd(mem_cmd),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.error(error),
		.status(status)
	);

	initial
	begin
		forever #4 clk = ~clk;
	end

	// Address on top and its inverse below
	function automatic logic [`EX_DATA_W-1:0] pattern_word(input int addr);
		logic [HALF_W-1:0] half;
		half = HALF_W'(addr);
		return {half, ~half};
	endfunction

	////////////////////////////////////////
	// Memory model
	////////////////////////////////////////

	always @(negedge clk)
	begin : memory_model
		logic [`EX_ADDR_W-1:0] idx;
		int n;
		mem_ready <= 1'b0;
		if (rst)
		begin
			busy <= 1'b0;
			// Fill differs from the pattern so that a lost write shows up
			for (int i = 0; i < (1 << `EX_ADDR_W); i++)
				mem_array[i] = 32'(i) * 32'h9e37_79b9;
		end
		else if (busy)
		begin
			if (wait_cnt > 1)
				wait_cnt <= wait_cnt - 1;
			else
			begin
				// Ready pulse is accepted at the next rising edge
				busy <= 1'b0;
				mem_ready <= 1'b1;
				idx = mem_cmd.addr[`EX_ADDR_W-1:0];
				n = cmd_log.size();
				// Walk order is W0 R0 W1 R1 and so on
				if (mem_cmd.rw !== (n % 2 == 0))
				begin
					$display("mismatch at %0t: mem_cmd.rw expected %0d, got %0d",
						$time, (n % 2 == 0), mem_cmd.rw);
					order_errors++;
				end
				if (mem_cmd.addr !== `EX_MEM_ADDR_W'((n / 2) % (LAST + 1)))
				begin
					$display("mismatch at %0t: mem_cmd.addr expected %0h, got %0h",
						$time, (n / 2) % (LAST + 1), mem_cmd.addr);
					order_errors++;
				end
				if (mem_cmd.rw && mem_cmd.wdata !== pattern_word(int'(mem_cmd.addr)))
				begin
					$display("mismatch at %0t: mem_cmd.wdata expected %0h, got %0h",
						$time, pattern_word(int'(mem_cmd.addr)), mem_cmd.wdata);
					order_errors++;
				end
				if (mem_cmd.rw)
					mem_array[idx] = mem_cmd.wdata;
				else if (corrupt_en && mem_cmd.addr == corrupt_addr)
					mem_rdata <= ~mem_array[idx];
				else
					mem_rdata <= mem_array[idx];
				cmd_log.push_back(mem_cmd);
			end
		end
		else if (mem_valid)
		begin
			// New command picks its latency
			busy <= 1'b1;
			if (stall_req != stall_ack)
			begin
				wait_cnt <= STALL_CYCLES;
				stall_ack <= stall_req;
			end
			else
				wait_cnt <= 1 + ($random(seed) & 3);
		end
	end

	// Waiting command must stay on the port
	always @(negedge clk)
	begin
		if (!rst && prev_valid && !mem_ready)
		begin
			held_cycles <= held_cycles + 1;
			if (!mem_valid || mem_cmd !== prev_cmd)
			begin
				$display("mismatch at %0t: mem_cmd expected %0h, got %0h",
					$time, prev_cmd, mem_cmd);
				hold_errors++;
			end
		end
		prev_valid <= mem_valid && !rst;
		prev_cmd <= mem_cmd;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_quiet_outputs();
		check_value("mem_valid", 0, mem_valid);
		check_value("error", 0, error);
		check_value("status", 0, status);
	endtask

	// Returns on the falling edge after an accepting rising edge
	task automatic wait_accept();
		@(negedge clk);
		while (!mem_ready)
			@(negedge clk);
	endtask

	// Negative addr matches any address
	task automatic wait_cmd(input logic rw, input int addr);
		wait_accept();
		while (mem_cmd.rw != rw || (addr >= 0 && int'(mem_cmd.addr) != addr))
			wait_accept();
	endtask

	// Enable then one ROM cycle before the first command
	task automatic start_walk();
		enable = 1'b1;
		@(negedge clk);
		check_value("mem_valid", 0, mem_valid);
		@(negedge clk);
		check_value("mem_valid", 1, mem_valid);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic check_reset_state();
		rst = 1'b1;
		repeat (5)
		begin
			@(negedge clk);
			check_quiet_outputs();
		end
		rst = 1'b0;
		@(negedge clk);
		check_quiet_outputs();
	endtask

	task automatic run_full_pass();
		start_walk();
		while (status.pass_count == 0)
			@(negedge clk);
		check_value("cmd_log.size", CMDS_PER_PASS, cmd_log.size());
		check_value("status.pass_count", 1, status.pass_count);
		check_value("error", 0, error);
		check_value("status.error_count", 0, status.error_count);
	endtask

	task automatic check_idle_gap(input int count);
		int low;
		repeat (count)
		begin
			wait_accept();
			low = 0;
			while (!mem_valid)
			begin
				low++;
				@(negedge clk);
			end
			check_value("idle gap length", GAP, low);
		end
	endtask

	task automatic check_back_pressure();
		int held_start;
		held_start = held_cycles;
		stall_req <= stall_req + 1;
		@(negedge clk);
		while (stall_ack != stall_req)
			@(negedge clk);
		wait_accept();
		if (held_cycles - held_start < STALL_CYCLES)
		begin
			$display("back-pressure: the forced %0d-cycle stall was not seen", STALL_CYCLES);
			test_errors++;
		end
	endtask

	task automatic check_corrupted_read();
		logic [`EX_CNT_W-1:0] err_start;
		err_start = status.error_count;
		// Arm after the write and well before the read
		wait_cmd(1'b1, CORRUPT_ADDR);
		corrupt_addr <= `EX_MEM_ADDR_W'(CORRUPT_ADDR);
		corrupt_en <= 1'b1;
		wait_cmd(1'b0, CORRUPT_ADDR);
		check_value("error", 1, error);
		check_value("status.error_count", err_start + 1'b1, status.error_count);
		check_value("status.fail_addr", CORRUPT_ADDR, status.fail_addr);
		corrupt_en <= 1'b0;
		wait_cmd(1'b0, -1);
		check_value("error", 0, error);
	endtask

	task automatic check_stop_resume();
		int log_size;
		// Drop enable inside a gap
		wait_accept();
		enable = 1'b0;
		log_size = cmd_log.size();
		repeat (30) @(negedge clk);
		repeat (20)
		begin
			@(negedge clk);
			if (mem_valid)
			begin
				$display("stop: mem_valid went high while enable was low");
				test_errors++;
			end
		end
		check_value("cmd_log.size", log_size, cmd_log.size());
		// Model checks that the walk continues in order
		start_walk();
		repeat (4) wait_accept();
	endtask

	initial
	begin
		rst = 1'b1;
		enable = 1'b0;
		stall_req = 0;
		corrupt_en = 1'b0;
		corrupt_addr = '0;
		check_reset_state();
		run_full_pass();
		check_idle_gap(4);
		check_back_pressure();
		check_corrupted_read();
		check_stop_resume();
		$display("errors: tests %0d, command order %0d, command hold %0d",
			test_errors, order_errors, hold_errors);
		if (test_errors + order_errors + hold_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: mem_exerciser.f
+incdir+hw
hw/mem_cmd_pkg.sv
hw/exerciser_pkg.sv
hw/pattern_rom.sv
hw/cmd_sequencer.sv
hw/readback_checker.sv
hw/mem_exerciser.sv
test/tb_mem_exerciser.sv

// File: Makefile
# Verilator build and run of the memory exerciser testbench

VERILATOR ?= verilator
TOP ?= tb_mem_exerciser
RTL_TOP ?= mem_exerciser
FILELIST ?= mem_exerciser.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS ?= hw/mem_cmd_pkg.sv hw/exerciser_pkg.sv hw/pattern_rom.sv \
	hw/cmd_sequencer.sv hw/readback_checker.sv hw/mem_exerciser.sv
FAIL_MSG ?= Simulation finished: FAIL
PASS_MSG ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+hw --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
